// ==== build.f ====
src/udp_pkg.sv
src/udp_ip_rx.sv
src/udp_ip_tx.sv
src/udp_block.sv
bench/udp_block_checker.sv
bench/udp_block_tb.sv

// ==== bench/udp_block_tb.sv ====
`timescale 1ns/1ps

// UDP layer testbench
// Random receive and transmit frames under back-pressure, checked by the checker
module udp_block_tb;
    import udp_pkg::*;

    localparam int FRAMES         = 200;
    localparam int TIMEOUT_CYCLES = 400 * 40 * 4;

    typedef logic [7:0] byte_q_t[$];

    logic          clk;
    logic          rst_n;
    logic          s_ip_hdr_valid, s_ip_hdr_ready;
    ip_hdr_t       s_ip_hdr;
    logic          s_ip_payload_valid, s_ip_payload_ready;
    payload_beat_t s_ip_payload;
    logic          m_ip_hdr_valid, m_ip_hdr_ready;
    ip_hdr_t       m_ip_hdr;
    logic          m_ip_payload_valid, m_ip_payload_ready;
    payload_beat_t m_ip_payload;
    logic          s_udp_hdr_valid, s_udp_hdr_ready;
    udp_hdr_t      s_udp_hdr;
    logic          s_udp_payload_valid, s_udp_payload_ready;
    payload_beat_t s_udp_payload;
    logic          m_udp_hdr_valid, m_udp_hdr_ready;
    udp_hdr_t      m_udp_hdr;
    logic          m_udp_payload_valid, m_udp_payload_ready;
    payload_beat_t m_udp_payload;
    logic          rx_busy, tx_busy;
    logic          rx_error_header_early_termination;
    logic          rx_error_payload_early_termination;
    logic          tx_error_payload_early_termination;
    int            cycles;
    int            seed_val;

    udp_block dut (.*);

    udp_block_checker chk (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Random back-pressure on every output
    always @(posedge clk) begin
        m_ip_hdr_ready      <= ($urandom % 4) != 0;
        m_ip_payload_ready  <= ($urandom % 4) != 0;
        m_udp_hdr_ready     <= ($urandom % 4) != 0;
        m_udp_payload_ready <= ($urandom % 4) != 0;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // One stream beat from bytes start up to stop, unused bytes random
    function automatic payload_beat_t make_beat(input byte_q_t bytes, input int start,
                                                input int stop);
        payload_beat_t b;
        int count;
        count  = (stop - start > 8) ? 8 : stop - start;
        b.data = {$urandom, $urandom};
        b.keep = '0;
        for (int j = 0; j < count; j++) begin
            b.data[8*j +: 8] = bytes[start + j];
            b.keep[j]        = 1'b1;
        end
        b.last = (start + 8 >= stop);
        b.user = 1'b0;
        return b;
    endfunction

    // Network byte order
    task automatic append_udp_header(inout byte_q_t q, input udp_hdr_t h);
        q.push_back(h.source_port[15:8]);
        q.push_back(h.source_port[7:0]);
        q.push_back(h.dest_port[15:8]);
        q.push_back(h.dest_port[7:0]);
        q.push_back(h.length[15:8]);
        q.push_back(h.length[7:0]);
        q.push_back(h.checksum[15:8]);
        q.push_back(h.checksum[7:0]);
    endtask

    task automatic expect_beats(input byte_q_t ob, input logic short_f, input bit rx_side);
        payload_beat_t b;
        for (int i = 0; i < ob.size(); i += 8) begin
            b      = make_beat(ob, i, ob.size());
            b.user = b.last && short_f;
            if (rx_side) chk.exp_udp_pay_q.push_back(b);
            else chk.exp_ip_pay_q.push_back(b);
        end
    endtask

    function automatic udp_hdr_t random_udp_header(input int ulen);
        udp_hdr_t h;
        h.ip          = {$urandom, $urandom, $urandom, $urandom, $urandom};
        h.source_port = $urandom;
        h.dest_port   = $urandom;
        h.length      = len_t'(ulen);
        h.checksum    = $urandom;
        return h;
    endfunction

    task automatic run_rx_frame();
        udp_hdr_t uh;
        byte_q_t  bytes;
        byte_q_t  ob;
        int       ulen;
        int       n;
        ulen = 9 + $urandom % 64;
        uh   = random_udp_header(ulen);
        if ($urandom % 10 == 0) n = 1 + $urandom % (ulen - 1);
        else n = ulen + (($urandom % 4 == 0) ? $urandom % 16 : 0);
        append_udp_header(bytes, uh);
        while (bytes.size() < n) bytes.push_back($urandom);
        while (bytes.size() > n) void'(bytes.pop_back());
        // Header beat ending the frame gives only the header error
        if (n <= 8) begin
            chk.exp_rx_hdr_err++;
        end else begin
            chk.exp_udp_hdr_q.push_back(uh);
            for (int i = 8; i < ((n < ulen) ? n : ulen); i++) ob.push_back(bytes[i]);
            expect_beats(ob, n < ulen, 1'b1);
            if (n < ulen) chk.exp_rx_pay_err++;
        end
        s_ip_hdr       <= uh.ip;
        s_ip_hdr_valid <= 1'b1;
        do @(negedge clk); while (!s_ip_hdr_ready);
        @(posedge clk);
        s_ip_hdr_valid <= 1'b0;
        for (int i = 0; i < n; i += 8) begin
            if ($urandom % 4 == 0) begin
                s_ip_payload_valid <= 1'b0;
                repeat (1 + $urandom % 3) @(posedge clk);
            end
            s_ip_payload       <= make_beat(bytes, i, n);
            s_ip_payload_valid <= 1'b1;
            do @(negedge clk); while (!s_ip_payload_ready);
            @(posedge clk);
        end
        s_ip_payload_valid <= 1'b0;
    endtask

    task automatic run_tx_frame();
        udp_hdr_t uh;
        ip_hdr_t  ih;
        byte_q_t  bytes;
        byte_q_t  ob;
        int       plen;
        int       n;
        plen = 1 + $urandom % 64;
        uh   = random_udp_header(plen + 8);
        if (plen > 1 && $urandom % 10 == 0) n = 1 + $urandom % (plen - 1);
        else n = plen + (($urandom % 4 == 0) ? $urandom % 16 : 0);
        for (int i = 0; i < n; i++) bytes.push_back($urandom);
        ih          = uh.ip;
        ih.protocol = 8'd17;
        ih.length   = len_t'(plen + 8 + 20);
        chk.exp_ip_hdr_q.push_back(ih);
        append_udp_header(ob, uh);
        for (int i = 0; i < ((n < plen) ? n : plen); i++) ob.push_back(bytes[i]);
        expect_beats(ob, n < plen, 1'b0);
        if (n < plen) chk.exp_tx_pay_err++;
        s_udp_hdr       <= uh;
        s_udp_hdr_valid <= 1'b1;
        do @(negedge clk); while (!s_udp_hdr_ready);
        @(posedge clk);
        s_udp_hdr_valid <= 1'b0;
        for (int i = 0; i < n; i += 8) begin
            if ($urandom % 4 == 0) begin
                s_udp_payload_valid <= 1'b0;
                repeat (1 + $urandom % 3) @(posedge clk);
            end
            s_udp_payload       <= make_beat(bytes, i, n);
            s_udp_payload_valid <= 1'b1;
            do @(negedge clk); while (!s_udp_payload_ready);
            @(posedge clk);
        end
        s_udp_payload_valid <= 1'b0;
    endtask

    initial begin
        seed_val            = $urandom(92391);
        cycles              = 0;
        rst_n               = 1'b0;
        s_ip_hdr_valid      = 1'b0;
        s_ip_hdr            = '0;
        s_ip_payload_valid  = 1'b0;
        s_ip_payload        = '0;
        s_udp_hdr_valid     = 1'b0;
        s_udp_hdr           = '0;
        s_udp_payload_valid = 1'b0;
        s_udp_payload       = '0;
        m_ip_hdr_ready      = 1'b0;
        m_ip_payload_ready  = 1'b0;
        m_udp_hdr_ready     = 1'b0;
        m_udp_payload_ready = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        fork
            for (int f = 0; f < FRAMES; f++) run_rx_frame();
            for (int f = 0; f < FRAMES; f++) run_tx_frame();
        join
        while (chk.exp_udp_hdr_q.size() || chk.exp_udp_pay_q.size() ||
               chk.exp_ip_hdr_q.size() || chk.exp_ip_pay_q.size()) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        chk.final_check();
        $display("Errors: %0d value mismatches, %0d other failures",
                 chk.value_errors, chk.other_errors);
        if (chk.value_errors == 0 && chk.other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/udp_block_checker.sv ====
`timescale 1ns/1ps

// UDP layer checker
// Compares accepted DUT outputs with expected queues and counts error pulses
module udp_block_checker
    import udp_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input logic          s_ip_hdr_valid,
    input logic          s_ip_hdr_ready,
    input ip_hdr_t       s_ip_hdr,
    input logic          s_ip_payload_valid,
    input logic          s_ip_payload_ready,
    input payload_beat_t s_ip_payload,
    input logic          m_ip_hdr_valid,
    input logic          m_ip_hdr_ready,
    input ip_hdr_t       m_ip_hdr,
    input logic          m_ip_payload_valid,
    input logic          m_ip_payload_ready,
    input payload_beat_t m_ip_payload,
    input logic          s_udp_hdr_valid,
    input logic          s_udp_hdr_ready,
    input udp_hdr_t      s_udp_hdr,
    input logic          s_udp_payload_valid,
    input logic          s_udp_payload_ready,
    input payload_beat_t s_udp_payload,
    input logic          m_udp_hdr_valid,
    input logic          m_udp_hdr_ready,
    input udp_hdr_t      m_udp_hdr,
    input logic          m_udp_payload_valid,
    input logic          m_udp_payload_ready,
    input payload_beat_t m_udp_payload,
    input logic          rx_busy,
    input logic          tx_busy,
    input logic          rx_error_header_early_termination,
    input logic          rx_error_payload_early_termination,
    input logic          tx_error_payload_early_termination
);

    // Wide enough for the full UDP header
    typedef logic [$bits(udp_hdr_t)-1:0] cmp_t;

    // Filled by the testbench as frames are generated
    udp_hdr_t      exp_udp_hdr_q[$];
    payload_beat_t exp_udp_pay_q[$];
    ip_hdr_t       exp_ip_hdr_q[$];
    payload_beat_t exp_ip_pay_q[$];
    int exp_rx_hdr_err = 0;
    int exp_rx_pay_err = 0;
    int exp_tx_pay_err = 0;
    int got_rx_hdr_err = 0;
    int got_rx_pay_err = 0;
    int got_tx_pay_err = 0;
    int value_errors   = 0;
    int other_errors   = 0;

    task automatic check_value(input string name, input cmp_t exp, input cmp_t got);
        if (exp !== got) begin
            $display("Fail time %0t signal %s expected %h actual %h", $time, name, exp, got);
            value_errors++;
        end
    endtask

    // Data is only compared on enabled bytes
    task automatic check_beat(input string name, input payload_beat_t exp,
                              input payload_beat_t got);
        check_value({name, ".keep"}, cmp_t'(exp.keep), cmp_t'(got.keep));
        check_value({name, ".last"}, cmp_t'(exp.last), cmp_t'(got.last));
        check_value({name, ".user"}, cmp_t'(exp.user), cmp_t'(got.user));
        for (int j = 0; j < 8; j++) begin
            if (exp.keep[j]) begin
                check_value({name, ".data"}, cmp_t'(exp.data[8*j +: 8]),
                            cmp_t'(got.data[8*j +: 8]));
            end
        end
    endtask

    task automatic report_unexpected(input string name);
        $display("Unexpected transfer on %s at time %0t with nothing expected", name, $time);
        other_errors++;
    endtask

    // Handshake signals are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                if (exp_udp_hdr_q.size() == 0) report_unexpected("m_udp_hdr");
                else check_value("m_udp_hdr", cmp_t'(exp_udp_hdr_q.pop_front()),
                                 cmp_t'(m_udp_hdr));
            end
            if (m_udp_payload_valid && m_udp_payload_ready) begin
                if (exp_udp_pay_q.size() == 0) report_unexpected("m_udp_payload");
                else check_beat("m_udp_payload", exp_udp_pay_q.pop_front(), m_udp_payload);
            end
            if (m_ip_hdr_valid && m_ip_hdr_ready) begin
                if (exp_ip_hdr_q.size() == 0) report_unexpected("m_ip_hdr");
                else check_value("m_ip_hdr", cmp_t'(exp_ip_hdr_q.pop_front()),
                                 cmp_t'(m_ip_hdr));
            end
            if (m_ip_payload_valid && m_ip_payload_ready) begin
                if (exp_ip_pay_q.size() == 0) report_unexpected("m_ip_payload");
                else check_beat("m_ip_payload", exp_ip_pay_q.pop_front(), m_ip_payload);
            end
            if (rx_error_header_early_termination) got_rx_hdr_err++;
            if (rx_error_payload_early_termination) got_rx_pay_err++;
            if (tx_error_payload_early_termination) got_tx_pay_err++;
        end
    end

    task automatic final_check();
        if (exp_udp_hdr_q.size() || exp_udp_pay_q.size() ||
            exp_ip_hdr_q.size() || exp_ip_pay_q.size()) begin
            $display("Expected output still missing at end of run");
            other_errors++;
        end
        check_value("rx_error_header_early_termination count", cmp_t'(exp_rx_hdr_err),
                    cmp_t'(got_rx_hdr_err));
        check_value("rx_error_payload_early_termination count", cmp_t'(exp_rx_pay_err),
                    cmp_t'(got_rx_pay_err));
        check_value("tx_error_payload_early_termination count", cmp_t'(exp_tx_pay_err),
                    cmp_t'(got_tx_pay_err));
        if (rx_busy || tx_busy) begin
            $display("Busy still high at end of run");
            other_errors++;
        end
    endtask

endmodule

// ==== src/udp_block.sv ====
`timescale 1ns/1ps

// UDP layer top level
// Receive path from the IP layer and transmit path towards it, fully independent
module udp_block
    import udp_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // IP frame input
    input  logic          s_ip_hdr_valid,
    output logic          s_ip_hdr_ready,
    input  ip_hdr_t       s_ip_hdr,
    input  logic          s_ip_payload_valid,
    output logic          s_ip_payload_ready,
    input  payload_beat_t s_ip_payload,

    // IP frame output
    output logic          m_ip_hdr_valid,
    input  logic          m_ip_hdr_ready,
    output ip_hdr_t       m_ip_hdr,
    output logic          m_ip_payload_valid,
    input  logic          m_ip_payload_ready,
    output payload_beat_t m_ip_payload,

    // UDP frame input
    input  logic          s_udp_hdr_valid,
    output logic          s_udp_hdr_ready,
    input  udp_hdr_t      s_udp_hdr,
    input  logic          s_udp_payload_valid,
    output logic          s_udp_payload_ready,
    input  payload_beat_t s_udp_payload,

    // UDP frame output
    output logic          m_udp_hdr_valid,
    input  logic          m_udp_hdr_ready,
    output udp_hdr_t      m_udp_hdr,
    output logic          m_udp_payload_valid,
    input  logic          m_udp_payload_ready,
    output payload_beat_t m_udp_payload,

    // Status
    output logic          rx_busy,
    output logic          tx_busy,
    output logic          rx_error_header_early_termination,
    output logic          rx_error_payload_early_termination,
    output logic          tx_error_payload_early_termination
);

    udp_ip_rx u_rx (
        .clk                             (clk),
        .rst_n                           (rst_n),
        .s_ip_hdr_valid                  (s_ip_hdr_valid),
        .s_ip_hdr_ready                  (s_ip_hdr_ready),
        .s_ip_hdr                        (s_ip_hdr),
        .s_ip_payload_valid              (s_ip_payload_valid),
        .s_ip_payload_ready              (s_ip_payload_ready),
        .s_ip_payload                    (s_ip_payload),
        .m_udp_hdr_valid                 (m_udp_hdr_valid),
        .m_udp_hdr_ready                 (m_udp_hdr_ready),
        .m_udp_hdr                       (m_udp_hdr),
        .m_udp_payload_valid             (m_udp_payload_valid),
        .m_udp_payload_ready             (m_udp_payload_ready),
        .m_udp_payload                   (m_udp_payload),
        .busy                            (rx_busy),
        .error_header_early_termination  (rx_error_header_early_termination),
        .error_payload_early_termination (rx_error_payload_early_termination)
    );

    udp_ip_tx u_tx (
        .clk                             (clk),
        .rst_n                           (rst_n),
        .s_udp_hdr_valid                 (s_udp_hdr_valid),
        .s_udp_hdr_ready                 (s_udp_hdr_ready),
        .s_udp_hdr                       (s_udp_hdr),
        .s_udp_payload_valid             (s_udp_payload_valid),
        .s_udp_payload_ready             (s_udp_payload_ready),
        .s_udp_payload                   (s_udp_payload),
        .m_ip_hdr_valid                  (m_ip_hdr_valid),
        .m_ip_hdr_ready                  (m_ip_hdr_ready),
        .m_ip_hdr                        (m_ip_hdr),
        .m_ip_payload_valid              (m_ip_payload_valid),
        .m_ip_payload_ready              (m_ip_payload_ready),
        .m_ip_payload                    (m_ip_payload),
        .busy                            (tx_busy),
        .error_payload_early_termination (tx_error_payload_early_termination)
    );

endmodule

// ==== src/udp_ip_tx.sv ====
`timescale 1ns/1ps

// UDP transmit path
// Builds the IP header, inserts the UDP header beat and trims the payload to length
module udp_ip_tx
    import udp_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    input  logic          s_udp_hdr_valid,
    output logic          s_udp_hdr_ready,
    input  udp_hdr_t      s_udp_hdr,

    input  logic          s_udp_payload_valid,
    output logic          s_udp_payload_ready,
    input  payload_beat_t s_udp_payload,

    output logic          m_ip_hdr_valid,
    input  logic          m_ip_hdr_ready,
    output ip_hdr_t       m_ip_hdr,

    output logic          m_ip_payload_valid,
    input  logic          m_ip_payload_ready,
    output payload_beat_t m_ip_payload,

    output logic          busy,
    output logic          error_payload_early_termination
);

    tx_state_t     state;
    udp_hdr_t      udp_hdr_reg;
    udp_hdr_t      hdr_src;
    ip_hdr_t       ip_hdr_next;
    len_t          remaining;
    logic          hdr_accept;
    logic          pay_accept;
    logic          hdr_out_free;
    logic          pay_out_free;
    logic          hdr_beat_load;
    logic          payload_early;
    payload_beat_t hdr_beat;
    payload_beat_t out_beat;

    assign hdr_out_free = !m_ip_hdr_valid || m_ip_hdr_ready;
    assign pay_out_free = !m_ip_payload_valid || m_ip_payload_ready;

    assign s_udp_hdr_ready = (state == TX_IDLE) && hdr_out_free;
    assign hdr_accept      = s_udp_hdr_valid && s_udp_hdr_ready;
    assign pay_accept      = s_udp_payload_valid && s_udp_payload_ready;

    always_comb begin
        case (state)
            TX_PAYLOAD: s_udp_payload_ready = pay_out_free;
            TX_DROP:    s_udp_payload_ready = 1'b1;
            default:    s_udp_payload_ready = 1'b0;
        endcase
    end

    // Header beat comes straight from the input unless it had to wait
    assign hdr_src       = (state == TX_IDLE) ? s_udp_hdr : udp_hdr_reg;
    assign hdr_beat_load = pay_out_free && (hdr_accept || state == TX_HEADER);

    always_comb begin
        ip_hdr_next          = s_udp_hdr.ip;
        ip_hdr_next.protocol = UDP_PROTOCOL;
        ip_hdr_next.length   = s_udp_hdr.length + IP_HDR_BYTES;
    end

    // Network byte order, byte 0 in the low bits
    always_comb begin
        hdr_beat.data = {hdr_src.checksum[7:0], hdr_src.checksum[15:8],
                         hdr_src.length[7:0], hdr_src.length[15:8],
                         hdr_src.dest_port[7:0], hdr_src.dest_port[15:8],
                         hdr_src.source_port[7:0], hdr_src.source_port[15:8]};
        hdr_beat.keep = '1;
        hdr_beat.last = (hdr_src.length <= UDP_HDR_BYTES);
        hdr_beat.user = 1'b0;
    end

    assign payload_early = beat_is_early(s_udp_payload, remaining);
    assign out_beat      = trim_beat(s_udp_payload, remaining);

    assign busy = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state                           <= TX_IDLE;
            remaining                       <= '0;
            m_ip_hdr_valid                  <= 1'b0;
            m_ip_payload_valid              <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            error_payload_early_termination <= 1'b0;

            if (m_ip_hdr_ready) begin
                m_ip_hdr_valid <= 1'b0;
            end
            if (m_ip_payload_ready) begin
                m_ip_payload_valid <= 1'b0;
            end

            case (state)
                TX_IDLE: begin
                    if (hdr_accept) begin
                        m_ip_hdr_valid <= 1'b1;
                        state          <= TX_HEADER;
                    end
                end
                TX_PAYLOAD: begin
                    if (pay_accept) begin
                        m_ip_payload_valid <= 1'b1;
                        if (payload_early) begin
                            error_payload_early_termination <= 1'b1;
                            state <= TX_IDLE;
                        end else if (remaining <= len_t'(BEAT_BYTES)) begin
                            state <= s_udp_payload.last ? TX_IDLE : TX_DROP;
                        end else begin
                            remaining <= remaining - len_t'(BEAT_BYTES);
                        end
                    end
                end
                TX_DROP: begin
                    if (pay_accept && s_udp_payload.last) begin
                        state <= TX_IDLE;
                    end
                end
                default: ;
            endcase

            // UDP header beat leaves in the header cycle or as soon as the output frees up
            if (hdr_beat_load) begin
                m_ip_payload_valid <= 1'b1;
                remaining          <= hdr_src.length - UDP_HDR_BYTES;
                state              <= hdr_beat.last ? TX_DROP : TX_PAYLOAD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            udp_hdr_reg <= s_udp_hdr;
            m_ip_hdr    <= ip_hdr_next;
        end
        if (hdr_beat_load) begin
            m_ip_payload <= hdr_beat;
        end else if (state == TX_PAYLOAD && pay_accept) begin
            m_ip_payload <= out_beat;
        end
    end

endmodule

// ==== src/udp_ip_rx.sv ====
`timescale 1ns/1ps

// UDP receive path
// Splits the UDP header beat off an IP frame and trims the payload to the UDP length
module udp_ip_rx
    import udp_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    input  logic          s_ip_hdr_valid,
    output logic          s_ip_hdr_ready,
    input  ip_hdr_t       s_ip_hdr,

    input  logic          s_ip_payload_valid,
    output logic          s_ip_payload_ready,
    input  payload_beat_t s_ip_payload,

    output logic          m_udp_hdr_valid,
    input  logic          m_udp_hdr_ready,
    output udp_hdr_t      m_udp_hdr,

    output logic          m_udp_payload_valid,
    input  logic          m_udp_payload_ready,
    output payload_beat_t m_udp_payload,

    output logic          busy,
    output logic          error_header_early_termination,
    output logic          error_payload_early_termination
);

    rx_state_t     state;
    ip_hdr_t       ip_hdr_reg;
    len_t          remaining;
    len_t          beat_length;
    logic          hdr_accept;
    logic          pay_accept;
    logic          hdr_out_free;
    logic          pay_out_free;
    logic          hdr_beat_bad;
    logic          payload_early;
    payload_beat_t out_beat;

    // Output registers take a new item when empty or drained this cycle
    assign hdr_out_free = !m_udp_hdr_valid || m_udp_hdr_ready;
    assign pay_out_free = !m_udp_payload_valid || m_udp_payload_ready;

    assign s_ip_hdr_ready = (state == RX_IDLE);
    assign hdr_accept     = s_ip_hdr_valid && s_ip_hdr_ready;
    assign pay_accept     = s_ip_payload_valid && s_ip_payload_ready;

    always_comb begin
        case (state)
            RX_HEADER:  s_ip_payload_ready = hdr_out_free;
            RX_PAYLOAD: s_ip_payload_ready = pay_out_free;
            RX_DROP:    s_ip_payload_ready = 1'b1;
            default:    s_ip_payload_ready = 1'b0;
        endcase
    end

    // UDP length sits in bytes 4 and 5, high byte first
    assign beat_length   = {s_ip_payload.data[39:32], s_ip_payload.data[47:40]};
    assign hdr_beat_bad  = s_ip_payload.last || (s_ip_payload.keep != '1);
    assign payload_early = beat_is_early(s_ip_payload, remaining);
    assign out_beat      = trim_beat(s_ip_payload, remaining);

    assign busy = (state != RX_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state                           <= RX_IDLE;
            remaining                       <= '0;
            m_udp_hdr_valid                 <= 1'b0;
            m_udp_payload_valid             <= 1'b0;
            error_header_early_termination  <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            error_header_early_termination  <= 1'b0;
            error_payload_early_termination <= 1'b0;

            if (m_udp_hdr_ready) begin
                m_udp_hdr_valid <= 1'b0;
            end
            if (m_udp_payload_ready) begin
                m_udp_payload_valid <= 1'b0;
            end

            case (state)
                RX_IDLE: begin
                    if (hdr_accept) begin
                        state <= RX_HEADER;
                    end
                end
                RX_HEADER: begin
                    if (pay_accept) begin
                        if (hdr_beat_bad) begin
                            error_header_early_termination <= 1'b1;
                            state <= s_ip_payload.last ? RX_IDLE : RX_DROP;
                        end else begin
                            m_udp_hdr_valid <= 1'b1;
                            if (beat_length > UDP_HDR_BYTES) begin
                                remaining <= beat_length - UDP_HDR_BYTES;
                                state     <= RX_PAYLOAD;
                            end else begin
                                // Empty datagram, rest of the IP frame is padding
                                remaining <= '0;
                                state     <= RX_DROP;
                            end
                        end
                    end
                end
                RX_PAYLOAD: begin
                    if (pay_accept) begin
                        m_udp_payload_valid <= 1'b1;
                        if (payload_early) begin
                            error_payload_early_termination <= 1'b1;
                            state <= RX_IDLE;
                        end else if (remaining <= len_t'(BEAT_BYTES)) begin
                            state <= s_ip_payload.last ? RX_IDLE : RX_DROP;
                        end else begin
                            remaining <= remaining - len_t'(BEAT_BYTES);
                        end
                    end
                end
                RX_DROP: begin
                    if (pay_accept && s_ip_payload.last) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Header and payload data registers
    always_ff @(posedge clk) begin
        if (hdr_accept) begin
            ip_hdr_reg <= s_ip_hdr;
        end
        if (state == RX_HEADER && pay_accept) begin
            m_udp_hdr.ip          <= ip_hdr_reg;
            m_udp_hdr.source_port <= {s_ip_payload.data[7:0], s_ip_payload.data[15:8]};
            m_udp_hdr.dest_port   <= {s_ip_payload.data[23:16], s_ip_payload.data[31:24]};
            m_udp_hdr.length      <= beat_length;
            m_udp_hdr.checksum    <= {s_ip_payload.data[55:48], s_ip_payload.data[63:56]};
        end
        if (state == RX_PAYLOAD && pay_accept) begin
            m_udp_payload <= out_beat;
        end
    end

endmodule

// ==== src/udp_pkg.sv ====
// UDP layer shared definitions
// Field widths, header and payload beat structs, FSM states and beat trimming helpers
package udp_pkg;

    typedef logic [63:0] data_word_t;
    typedef logic [7:0]  keep_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;
    typedef logic [31:0] ip_addr_t;

    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        len_t        length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
    } ip_hdr_t;

    typedef struct packed {
        ip_hdr_t     ip;
        port_t       source_port;
        port_t       dest_port;
        len_t        length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // User flags a bad frame on its last beat
    typedef struct packed {
        data_word_t data;
        keep_t      keep;
        logic       last;
        logic       user;
    } payload_beat_t;

    localparam logic [7:0] UDP_PROTOCOL  = 8'd17;
    localparam len_t       UDP_HDR_BYTES = 16'd8;
    localparam len_t       IP_HDR_BYTES  = 16'd20;
    localparam int         BEAT_BYTES    = 8;

    typedef enum logic [1:0] {RX_IDLE, RX_HEADER, RX_PAYLOAD, RX_DROP} rx_state_t;
    typedef enum logic [1:0] {TX_IDLE, TX_HEADER, TX_PAYLOAD, TX_DROP} tx_state_t;

    // Low bytes enabled up to the given count
    function automatic keep_t keep_mask(input len_t bytes);
        keep_t mask;
        mask = '0;
        for (int i = 0; i < BEAT_BYTES; i++) begin
            if (bytes > len_t'(i)) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic logic [3:0] keep_count(input keep_t keep);
        logic [3:0] count;
        count = '0;
        for (int i = 0; i < BEAT_BYTES; i++) begin
            count = count + 4'(keep[i]);
        end
        return count;
    endfunction

    // Input frame ends before the datagram is complete
    function automatic logic beat_is_early(input payload_beat_t beat, input len_t remaining);
        return beat.last && (len_t'(keep_count(beat.keep)) < remaining);
    endfunction

    // Output beat for a payload beat with the given bytes still owed
    function automatic payload_beat_t trim_beat(input payload_beat_t beat, input len_t remaining);
        payload_beat_t trimmed;
        trimmed = beat;
        if (beat_is_early(beat, remaining)) begin
            trimmed.last = 1'b1;
            trimmed.user = 1'b1;
        end else if (remaining <= len_t'(BEAT_BYTES)) begin
            trimmed.keep = keep_mask(remaining);
            trimmed.last = 1'b1;
            trimmed.user = beat.user & beat.last;
        end else begin
            trimmed.last = 1'b0;
            trimmed.user = 1'b0;
        end
        return trimmed;
    endfunction

endpackage
